//--- src/sched_pkg.sv
`default_nettype none

package sched_pkg;

    // ==================================================================
    // Widths and scalar types
    // ==================================================================

    // Block RAM address width for both ifmap and weight memories
    localparam int ADDR_W = 10;

    // Layer select, four layers in the network
    typedef logic [1:0] layer_t;
    // Batch id, forms the upper part of the absolute tile
    typedef logic [2:0] batch_t;
    // Pass index inside one batch, up to 1024 passes
    typedef logic [9:0] pass_cnt_t;
    // Tile inside the batch, up to 8 tiles
    typedef logic [2:0] tile_t;
    // Row inside the tile, up to 256 rows
    typedef logic [7:0] row_t;
    // Absolute tile id, batch on top and tile below
    typedef logic [5:0] abs_tile_t;

    // ==================================================================
    // Packed structs
    // ==================================================================

    // Inclusive memory window
    typedef struct packed {
        logic [ADDR_W-1:0] first;
        logic [ADDR_W-1:0] last;
    } addr_range_t;

    // Per-pass context handed to the loaders
    typedef struct packed {
        layer_t    layer;
        abs_tile_t tile;
        row_t      row;
        logic [3:0] if_sel;
    } pass_desc_t;

    // Decoded position of the current pass
    typedef struct packed {
        tile_t tile;
        row_t  row;
    } pass_pos_t;

    // ==================================================================
    // Per-layer table
    // ==================================================================

    // Rows per tile as a power of two: 32, 64, 128, 256
    function automatic logic [3:0] rows_log2(input layer_t layer);
        logic [3:0] v;
        case (layer)
            2'd0: v = 4'd5;
            2'd1: v = 4'd6;
            2'd2: v = 4'd7;
            default: v = 4'd8;
        endcase
        return v;
    endfunction

    // Index of the final pass in a batch
    function automatic pass_cnt_t last_pass(input layer_t layer);
        pass_cnt_t v;
        case (layer)
            2'd0: v = 10'd127;
            2'd1: v = 10'd255;
            default: v = 10'd1023;
        endcase
        return v;
    endfunction

    // Ifmap words per 16-row segment, as a power of two
    function automatic logic [3:0] ifmap_seg_log2(input layer_t layer);
        logic [3:0] v;
        case (layer)
            2'd0, 2'd1: v = 4'd8;
            2'd2: v = 4'd7;
            default: v = 4'd6;
        endcase
        return v;
    endfunction

    // Weight words per tile, as a power of two
    function automatic logic [3:0] weight_tile_log2(input layer_t layer);
        logic [3:0] v;
        case (layer)
            2'd0, 2'd1: v = 4'd8;
            2'd2: v = 4'd7;
            default: v = 4'd6;
        endcase
        return v;
    endfunction

endpackage

`default_nettype wire

//--- src/pass_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module pass_decoder
    import sched_pkg::*;
(
    input  layer_t    layer,
    input  pass_cnt_t pass_idx,
    output pass_pos_t pos,
    output logic      last
);

    // ==================================================================
    // Layer-aware split of the pass counter
    // ==================================================================

    // Number of row bits for the active layer
    logic [3:0] row_sh;
    // Mask selecting the row bits
    pass_cnt_t  row_mask;
    // Row bits left in place
    pass_cnt_t  row_bits;
    // Counter shifted down so the tile sits at bit 0
    pass_cnt_t  tile_bits;
    // Final pass for this layer
    pass_cnt_t  pass_end;

    always_comb begin
        row_sh   = rows_log2(layer);
        // All ones below the tile boundary
        row_mask = (pass_cnt_t'(1) << row_sh) - pass_cnt_t'(1);
        row_bits = pass_idx & row_mask;
        // Tile is whatever lies above the row field
        tile_bits = pass_idx >> row_sh;
    end

    // Row field never exceeds 8 bits, tile never exceeds 3
    always_comb begin
        pos.row  = row_bits[7:0];
        pos.tile = tile_bits[2:0];
    end

    // ==================================================================
    // End of batch detect
    // ==================================================================

    // Layers 2 and 3 share the same pass count
    assign pass_end = last_pass(layer);

    // High for the whole final pass, sequencer samples it on trans_done
    assign last = (pass_idx == pass_end);

endmodule

`default_nettype wire

//--- src/pass_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module pass_sequencer
    import sched_pkg::*;
#(
    parameter int SETTLE_CYCLES = 3
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      trans_done,
    input  logic      last,
    output pass_cnt_t pass_idx,
    output logic      issue,
    output logic      fire_trans,
    output logic      done
);

    // ==================================================================
    // Settle timer sizing
    // ==================================================================

    // At least one bit even for a single settle cycle
    localparam int TMR_W = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES) : 1;
    // Timer value on the final settle cycle
    localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(SETTLE_CYCLES - 1);

    // Pass flow states
    typedef enum logic [2:0] {
        S_IDLE,
        S_ISSUE,
        S_SETTLE,
        S_FIRE,
        S_WAIT
    } state_t;

    state_t           state_q;
    state_t           state_d;
    logic [TMR_W-1:0] settle_q;
    // Transpose finished for the current pass
    logic             pass_adv;
    // Final pass retired, done follows one cycle later
    logic             batch_end_q;

    assign pass_adv = (state_q == S_WAIT) && trans_done;

    // ==================================================================
    // Next state
    // ==================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            // Start is ignored outside idle
            S_IDLE: begin
                if (start) begin
                    state_d = S_ISSUE;
                end
            end
            S_ISSUE: state_d = S_SETTLE;
            // Give the block RAMs time to settle on new ranges
            S_SETTLE: begin
                if (settle_q == TMR_LAST) begin
                    state_d = S_FIRE;
                end
            end
            S_FIRE: state_d = S_WAIT;
            // No timeout, transpose unit sets the pace
            S_WAIT: begin
                if (trans_done) begin
                    state_d = last ? S_IDLE : S_ISSUE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    // ==================================================================
    // State, timer and pass counter
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= S_IDLE;
            settle_q <= '0;
            pass_idx <= '0;
        end else begin
            state_q <= state_d;
            // Count only while settling, park at zero otherwise
            if (state_q == S_SETTLE && settle_q != TMR_LAST) begin
                settle_q <= settle_q + 1'b1;
            end else begin
                settle_q <= '0;
            end
            // Advance per pass, wrap to zero after the final one
            if (pass_adv) begin
                pass_idx <= last ? '0 : pass_idx + 1'b1;
            end
        end
    end

    // Done is two stages behind the final trans_done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            batch_end_q <= 1'b0;
            done        <= 1'b0;
        end else begin
            batch_end_q <= pass_adv && last;
            done        <= batch_end_q;
        end
    end

    // Strobes to the dispatch stage
    assign issue      = (state_q == S_ISSUE);
    assign fire_trans = (state_q == S_FIRE);

endmodule

`default_nettype wire

//--- src/pass_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module pass_dispatch
    import sched_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  layer_t      layer,
    input  batch_t      batch,
    input  pass_pos_t   pos,
    input  logic        issue,
    input  logic        fire_trans,
    output logic        load_start,
    output pass_desc_t  desc,
    output addr_range_t if_range,
    output addr_range_t w_range,
    output logic        trans_start
);

    // ==================================================================
    // Address window math
    // ==================================================================

    // Shift amounts from the layer table
    logic [3:0]        seg_sh;
    logic [3:0]        wt_sh;
    // Window sizes in words
    logic [ADDR_W-1:0] seg_size;
    logic [ADDR_W-1:0] wt_size;
    // Ifmap segment index, one per 16 rows
    logic [ADDR_W-1:0] seg_num;
    // Tile index widened to address width
    logic [ADDR_W-1:0] tile_num;

    addr_range_t if_next;
    addr_range_t w_next;
    pass_desc_t  desc_next;

    always_comb begin
        seg_sh   = ifmap_seg_log2(layer);
        wt_sh    = weight_tile_log2(layer);
        seg_size = ADDR_W'(1) << seg_sh;
        wt_size  = ADDR_W'(1) << wt_sh;
        seg_num  = ADDR_W'(pos.row >> 4);
        tile_num = ADDR_W'(pos.tile);
    end

    // Ifmap window covers one segment of rows
    always_comb begin
        if_next.first = seg_num << seg_sh;
        if_next.last  = if_next.first + (seg_size - ADDR_W'(1));
    end

    // Weight window covers one tile
    always_comb begin
        w_next.first = tile_num << wt_sh;
        w_next.last  = w_next.first + (wt_size - ADDR_W'(1));
    end

    // ==================================================================
    // Pass descriptor
    // ==================================================================
    always_comb begin
        desc_next.layer  = layer;
        // Batch on top so each batch owns its own tile space
        desc_next.tile   = {batch, pos.tile};
        desc_next.row    = pos.row;
        // Position within the 16-row ifmap segment
        desc_next.if_sel = pos.row[3:0];
    end

    // ==================================================================
    // Output registers
    // ==================================================================

    // Context captured on issue and held until the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            desc     <= '0;
            if_range <= '0;
            w_range  <= '0;
        end else if (issue) begin
            desc     <= desc_next;
            if_range <= if_next;
            w_range  <= w_next;
        end
    end

    // Single-cycle pulses, one cycle behind the strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_start  <= 1'b0;
            trans_start <= 1'b0;
        end else begin
            // Lines up with the freshly loaded descriptor
            load_start  <= issue;
            trans_start <= fire_trans;
        end
    end

endmodule

`default_nettype wire

//--- src/pass_scheduler_top.sv
`timescale 1ns/10ps
`default_nettype none

module pass_scheduler_top
    import sched_pkg::*;
#(
    parameter int SETTLE_CYCLES = 3
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  layer_t      layer,
    input  batch_t      batch,
    input  logic        trans_done,
    output logic        load_start,
    output pass_desc_t  desc,
    output addr_range_t if_range,
    output addr_range_t w_range,
    output logic        trans_start,
    output logic        done
);

    // ==================================================================
    // Internal nets
    // ==================================================================

    // Current pass, already advanced when issue fires
    pass_cnt_t pass_idx;
    logic      issue;
    logic      fire_trans;
    // Decoded tile and row
    pass_pos_t pos;
    // Final pass of the batch
    logic      last;

    // Control FSM
    pass_sequencer #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .trans_done (trans_done),
        .last       (last),
        .pass_idx   (pass_idx),
        .issue      (issue),
        .fire_trans (fire_trans),
        .done       (done)
    );

    // Counter to tile and row
    pass_decoder u_decoder (
        .layer    (layer),
        .pass_idx (pass_idx),
        .pos      (pos),
        .last     (last)
    );

    // Ranges, descriptor and pulses
    pass_dispatch u_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .layer       (layer),
        .batch       (batch),
        .pos         (pos),
        .issue       (issue),
        .fire_trans  (fire_trans),
        .load_start  (load_start),
        .desc        (desc),
        .if_range    (if_range),
        .w_range     (w_range),
        .trans_start (trans_start)
    );

endmodule

`default_nettype wire

//--- verification/tb_pass_scheduler.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pass_scheduler
    import sched_pkg::*;
();

    // ==================================================================
    // Constants and signals
    // ==================================================================
    localparam int SETTLE     = 3;
    localparam int NUM_RUNS   = 4;
    localparam int CP_PER_RUN = 4;
    // Words per golden line, one run line then its checkpoints
    localparam int REC_WORDS  = 9;
    localparam int RUN_WORDS  = REC_WORDS * (CP_PER_RUN + 1);
    localparam int GOLD_WORDS = RUN_WORDS * NUM_RUNS;

    logic        clk;
    logic        rst_n;
    logic        start;
    layer_t      layer;
    batch_t      batch;
    logic        trans_done;
    logic        load_start;
    pass_desc_t  desc;
    addr_range_t if_range;
    addr_range_t w_range;
    logic        trans_start;
    logic        done;

    logic [11:0] golden_mem [0:GOLD_WORDS-1];

    int          cyc;
    int          cyc_limit;
    int          err_count;
    int          tests_ok;
    int          tests_run;
    int          cur_run;
    // Monitor bookkeeping for the active batch
    int          pass_count;
    int          done_count;
    int          cp_hits;
    int          start_cyc;
    int          load_cyc;
    int          tdone_cyc;
    logic        busy;
    logic        trans_pending;
    logic [3:0]  resp_cnt;

    pass_scheduler_top #(
        .SETTLE_CYCLES (SETTLE)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .layer       (layer),
        .batch       (batch),
        .trans_done  (trans_done),
        .load_start  (load_start),
        .desc        (desc),
        .if_range    (if_range),
        .w_range     (w_range),
        .trans_start (trans_start),
        .done        (done)
    );

    always #5 clk = ~clk;

    // Cycle counter and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc_limit > 0 && cyc >= cyc_limit) begin
            $display("timeout: scheduler never finished");
            $display("tests failed");
            $finish;
        end
    end

    // Transpose unit model, random latency of 1 to 8 cycles
    always @(posedge clk) begin
        trans_done <= 1'b0;
        if (trans_start) begin
            resp_cnt <= 4'(($urandom % 8) + 1);
        end else if (resp_cnt != 0) begin
            resp_cnt <= resp_cnt - 1'b1;
            if (resp_cnt == 4'd1) begin
                trans_done <= 1'b1;
            end
        end
    end

    // ==================================================================
    // Checking helpers
    // ==================================================================
    task automatic compare_field(input int idx, input string name,
                                 input logic [11:0] got, input logic [11:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: pass %0d %s is %h, expected %h",
                     $time, idx, name, got, exp);
            err_count++;
        end
    endtask

    // Compare issued outputs against a matching checkpoint, if any
    task automatic compare_checkpoint(input int idx);
        int base;
        int rec;
        base = cur_run * RUN_WORDS;
        for (int c = 0; c < CP_PER_RUN; c++) begin
            rec = base + REC_WORDS * (c + 1);
            if (int'(golden_mem[rec + 1]) == idx) begin
                cp_hits <= cp_hits + 1;
                compare_field(idx, "layer", 12'(desc.layer), golden_mem[base + 1]);
                compare_field(idx, "row", 12'(desc.row), golden_mem[rec + 2]);
                compare_field(idx, "abs tile", 12'(desc.tile), golden_mem[rec + 3]);
                compare_field(idx, "ifmap select", 12'(desc.if_sel), golden_mem[rec + 4]);
                compare_field(idx, "ifmap first", 12'(if_range.first), golden_mem[rec + 5]);
                compare_field(idx, "ifmap last", 12'(if_range.last), golden_mem[rec + 6]);
                compare_field(idx, "weight first", 12'(w_range.first), golden_mem[rec + 7]);
                compare_field(idx, "weight last", 12'(w_range.last), golden_mem[rec + 8]);
            end
        end
    endtask

    task automatic log_result(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: bad, %0d errors", name, err_count - errs_before);
        end
    endtask

    // ==================================================================
    // Output monitor
    // ==================================================================
    always @(posedge clk) begin
        if (rst_n) begin
            // Only a start seen while idle opens a batch
            if (start && !busy) begin
                busy       <= 1'b1;
                start_cyc  <= cyc;
                pass_count <= 0;
                done_count <= 0;
                cp_hits    <= 0;
            end
            if (trans_done) begin
                tdone_cyc     <= cyc;
                trans_pending <= 1'b0;
            end
            if (load_start) begin
                load_cyc   <= cyc;
                pass_count <= pass_count + 1;
                if (pass_count == 0 && cyc - start_cyc != 2) begin
                    $display("[FAIL] %0t ns: load_start %0d cycles after start, expected 2",
                             $time, cyc - start_cyc);
                    err_count++;
                end
                if (pass_count != 0 && cyc - tdone_cyc != 2) begin
                    $display("[FAIL] %0t ns: load_start %0d cycles after trans_done",
                             $time, cyc - tdone_cyc);
                    err_count++;
                end
                compare_checkpoint(pass_count);
            end
            if (trans_start) begin
                if (trans_pending) begin
                    $display("[FAIL] %0t ns: second trans_start before trans_done", $time);
                    err_count++;
                end
                if (cyc - load_cyc != SETTLE + 1) begin
                    $display("[FAIL] %0t ns: trans_start %0d cycles after load_start",
                             $time, cyc - load_cyc);
                    err_count++;
                end
                trans_pending <= 1'b1;
            end
            if (done) begin
                done_count <= done_count + 1;
                busy       <= 1'b0;
            end
        end
    end

    // ==================================================================
    // Stimulus
    // ==================================================================
    initial begin
        int          errs_before;
        int          base;
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        layer = '0;
        batch = '0;
        trans_done = 1'b0;
        resp_cnt = '0;
        busy = 1'b0;
        trans_pending = 1'b0;
        cyc = 0;
        cyc_limit = 0;
        err_count = 0;
        tests_ok = 0;
        tests_run = 0;
        cur_run = 0;
        pass_count = 0;
        done_count = 0;
        cp_hits = 0;
        start_cyc = 0;
        load_cyc = 0;
        tdone_cyc = 0;
        void'($urandom(32'hc1f67570));
        $readmemh("verification/pass_scheduler_golden.txt", golden_mem);

        // Limit scales with the total pass count of all runs
        cyc_limit = 1000;
        for (int r = 0; r < NUM_RUNS; r++) begin
            base = r * RUN_WORDS;
            cyc_limit += int'(golden_mem[base + 3]) * 20;
            if (golden_mem[base] != 12'h1) begin
                $display("golden file has no run line at word %0d", base);
                err_count++;
            end
            for (int c = 1; c <= CP_PER_RUN; c++) begin
                if (golden_mem[base + REC_WORDS * c] != 12'h2) begin
                    $display("golden file has no checkpoint line at word %0d",
                             base + REC_WORDS * c);
                    err_count++;
                end
            end
        end

        // Reset values
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        errs_before = err_count;
        if (load_start !== 1'b0 || trans_start !== 1'b0 || done !== 1'b0) begin
            $display("[FAIL] %0t ns: pulse outputs not low after reset", $time);
            err_count++;
        end
        if (desc !== '0 || if_range !== '0 || w_range !== '0) begin
            $display("[FAIL] %0t ns: held outputs not zero after reset", $time);
            err_count++;
        end
        log_result("reset", errs_before);

        // One batch per layer
        for (int r = 0; r < NUM_RUNS; r++) begin
            base = r * RUN_WORDS;
            errs_before = err_count;
            @(posedge clk);
            cur_run = r;
            layer <= layer_t'(golden_mem[base + 1]);
            batch <= batch_t'(golden_mem[base + 2]);
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            @(posedge clk);
            // Stray start in the middle of the batch
            while (pass_count < 3) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            while (done_count == 0) @(posedge clk);
            // Quiet window to catch a late pass or a second done
            repeat (20) @(posedge clk);
            if (pass_count != int'(golden_mem[base + 3])) begin
                $display("[FAIL] %0t ns: run %0d issued %0d passes, expected %0d",
                         $time, r, pass_count, int'(golden_mem[base + 3]));
                err_count++;
            end
            if (done_count != 1) begin
                $display("[FAIL] %0t ns: run %0d saw %0d done pulses, expected 1",
                         $time, r, done_count);
                err_count++;
            end
            if (cp_hits != CP_PER_RUN) begin
                $display("[FAIL] %0t ns: run %0d reached %0d of %0d checkpoints",
                         $time, r, cp_hits, CP_PER_RUN);
                err_count++;
            end
            log_result($sformatf("layer %0d batch", golden_mem[base + 1]), errs_before);
        end

        $display("summary: %0d of %0d tests ok, %0d errors", tests_ok, tests_run, err_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
src/sched_pkg.sv
src/pass_decoder.sv
src/pass_sequencer.sv
src/pass_dispatch.sv
src/pass_scheduler_top.sv
verification/tb_pass_scheduler.sv

//--- verification/pass_scheduler_golden.txt
// run:        1 layer batch passes 000 000 000 000 000
// checkpoint: 2 pass row abs_tile if_sel if_first if_last w_first w_last
1 0 5 080 000 000 000 000 000
2 000 00 28 0 000 0FF 000 0FF
2 010 10 28 0 100 1FF 000 0FF
2 020 00 29 0 000 0FF 100 1FF
2 07F 1F 2B F 100 1FF 300 3FF
1 1 2 100 000 000 000 000 000
2 000 00 10 0 000 0FF 000 0FF
2 030 30 10 0 300 3FF 000 0FF
2 040 00 11 0 000 0FF 100 1FF
2 0FF 3F 13 F 300 3FF 300 3FF
1 2 7 400 000 000 000 000 000
2 000 00 38 0 000 07F 000 07F
2 050 50 38 0 280 2FF 000 07F
2 080 00 39 0 000 07F 080 0FF
2 3FF 7F 3F F 380 3FF 380 3FF
1 3 1 400 000 000 000 000 000
2 000 00 08 0 000 03F 000 03F
2 0F0 F0 08 0 3C0 3FF 000 03F
2 200 00 0A 0 000 03F 080 0BF
2 3FF FF 0B F 3C0 3FF 0C0 0FF
